//--- common/core_pkg.sv
// DTCM window is fixed at build time; opcode encodings are private to this pipe
package core_pkg;

	localparam int XLEN   = 32;	// data and address width
	localparam int REG_AW = 5;
	localparam int STRB_W = 4;	// one strobe bit per byte lane

	// accesses inside [DTCM_BASE, DTCM_BASE + DTCM_SIZE) use the dtcm port
	localparam logic [XLEN-1:0] DTCM_BASE = 32'h2000_0000;
	localparam logic [XLEN-1:0] DTCM_SIZE = 32'h0001_0000;	// 64 KiB

	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_SLT,
		OP_SLTU,
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LBU,
		OP_LHU,
		OP_SB,
		OP_SH,
		OP_SW
	} exec_op_e;

	// dmem_ctrl sequencer
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_REQ,	// holding the port until it takes the request
		MEM_WAIT	// load sent, waiting on read data
	} mem_state_e;

	function automatic logic is_load(exec_op_e op);
		return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	endfunction

	function automatic logic is_store(exec_op_e op);
		return op inside {OP_SB, OP_SH, OP_SW};
	endfunction

endpackage

//--- common/stage_if.sv
// valid/ready between alu_stage and dmem_ctrl; payload must stay put while valid waits
`timescale 1ns/1ps

interface stage_if import core_pkg::*; ();

	logic              valid;
	logic              ready;
	exec_op_e          op;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   result;	// alu value or effective address
	logic [XLEN-1:0]   store_data;

	modport source (
		output valid, op, rd, result, store_data,
		input  ready
	);

	modport sink (
		input  valid, op, rd, result, store_data,
		output ready
	);

endinterface

//--- common/wb_if.sv
// no back-pressure here, the writeback side takes an item every cycle
`timescale 1ns/1ps

interface wb_if import core_pkg::*; ();

	logic              valid;
	exec_op_e          op;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   result;	// byte address for loads
	logic [XLEN-1:0]   load_data;	// raw word from the memory port

	modport source (
		output valid, op, rd, result, load_data
	);

	modport sink (
		input  valid, op, rd, result, load_data
	);

endinterface

//--- src/alu_stage.sv
// single-entry issue register; shifts use src2[4:0], loads and stores get src1 + imm
`timescale 1ns/1ps

module alu_stage import core_pkg::*; (
	input  logic              cpu_clk,
	input  logic              rst,
	input  logic              issue_valid,
	output logic              issue_ready,
	input  exec_op_e          issue_op,
	input  logic [REG_AW-1:0] issue_rd,
	input  logic [XLEN-1:0]   issue_src1,
	input  logic [XLEN-1:0]   issue_src2,
	input  logic [XLEN-1:0]   issue_imm,
	stage_if.source           ex
);

	logic              run_q;	// low through reset, high from the next cycle on
	logic              valid_q;
	exec_op_e          op_q;
	logic [REG_AW-1:0] rd_q;
	logic [XLEN-1:0]   result_q;
	logic [XLEN-1:0]   store_data_q;

	logic [XLEN-1:0]   alu_out;
	logic [4:0]        shamt;
	logic              issue_fire;

	assign shamt = issue_src2[4:0];

	// take a new item when empty or when the held one leaves this cycle
	assign issue_ready = run_q && (!valid_q || ex.ready);
	assign issue_fire  = issue_valid && issue_ready;

	always_comb begin
		case (issue_op)
			OP_ADD:  alu_out = issue_src1 + issue_src2;
			OP_SUB:  alu_out = issue_src1 - issue_src2;
			OP_AND:  alu_out = issue_src1 & issue_src2;
			OP_OR:   alu_out = issue_src1 | issue_src2;
			OP_XOR:  alu_out = issue_src1 ^ issue_src2;
			OP_SLL:  alu_out = issue_src1 << shamt;
			OP_SRL:  alu_out = issue_src1 >> shamt;
			OP_SRA:  alu_out = $signed(issue_src1) >>> shamt;
			OP_SLT:  alu_out = XLEN'($signed(issue_src1) < $signed(issue_src2));
			OP_SLTU: alu_out = XLEN'(issue_src1 < issue_src2);
			default: alu_out = issue_src1 + issue_imm;	// load/store address
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			run_q   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (issue_fire)
				valid_q <= 1'b1;
			else if (ex.ready)
				valid_q <= 1'b0;	// item handed to dmem_ctrl
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (issue_fire) begin
			op_q         <= issue_op;
			rd_q         <= issue_rd;
			result_q     <= alu_out;
			store_data_q <= issue_src2;	// only meaningful for stores
		end
	end

	assign ex.valid      = valid_q;
	assign ex.op         = op_q;
	assign ex.rd         = rd_q;
	assign ex.result     = result_q;
	assign ex.store_data = store_data_q;

endmodule

//--- dmem/dmem_ctrl.sv
// one access outstanding at a time; address bits below the access size are dropped, no trap
`timescale 1ns/1ps

module dmem_ctrl import core_pkg::*; (
	input  logic              cpu_clk,
	input  logic              rst,

	// tightly coupled data memory
	output logic              dtcm_access,
	input  logic              dtcm_ready,
	output logic              dtcm_wr,
	output logic [STRB_W-1:0] dtcm_strobe,
	output logic [XLEN-1:0]   dtcm_addr,
	output logic [XLEN-1:0]   dtcm_wdata,
	input  logic [XLEN-1:0]   dtcm_rdata,
	input  logic              dtcm_rdata_valid,

	// system bus
	output logic              bus_access,
	input  logic              bus_full,
	output logic              bus_wr,
	output logic [STRB_W-1:0] bus_strobe,
	output logic [XLEN-1:0]   bus_addr,
	output logic [XLEN-1:0]   bus_wdata,
	input  logic [XLEN-1:0]   bus_rdata,
	input  logic              bus_rdata_valid,

	stage_if.sink             ex,
	wb_if.source              wb
);

	mem_state_e        state_q;

	logic              accept;
	logic              ex_mem;	// incoming op touches memory
	logic              hit_dtcm;
	logic              byte_acc;
	logic              half_acc;
	logic [XLEN-1:0]   offset;
	logic [STRB_W-1:0] strobe;
	logic [XLEN-1:0]   wdata;

	// accepted op, also the payload seen on wb_if
	exec_op_e          op_q;
	logic [REG_AW-1:0] rd_q;
	logic [XLEN-1:0]   result_q;
	logic [XLEN-1:0]   wdata_q;
	logic [STRB_W-1:0] strobe_q;
	logic              wr_q;
	logic              dtcm_sel_q;
	logic [XLEN-1:0]   load_data_q;
	logic              wb_valid_q;

	logic              req_done;
	logic              rdata_valid;
	logic [XLEN-1:0]   rdata;
	logic [XLEN-1:0]   word_addr;

	assign ex.ready = (state_q == MEM_IDLE);	// stalls issue while memory is busy
	assign accept   = ex.valid && ex.ready;
	assign ex_mem   = is_load(ex.op) || is_store(ex.op);

	// below the base the subtraction wraps high, so one compare covers both ends
	assign offset   = ex.result - DTCM_BASE;
	assign hit_dtcm = (offset < DTCM_SIZE);

	assign byte_acc = ex.op inside {OP_LB, OP_LBU, OP_SB};
	assign half_acc = ex.op inside {OP_LH, OP_LHU, OP_SH};

	// lanes picked by size and low address bits, data copied to every lane
	always_comb begin
		if (byte_acc) begin
			strobe = STRB_W'(1) << ex.result[1:0];
			wdata  = {4{ex.store_data[7:0]}};
		end else if (half_acc) begin
			strobe = ex.result[1] ? 4'b1100 : 4'b0011;
			wdata  = {2{ex.store_data[15:0]}};
		end else begin
			strobe = '1;
			wdata  = ex.store_data;
		end
	end

	assign req_done    = dtcm_sel_q ? dtcm_ready : !bus_full;
	assign rdata_valid = dtcm_sel_q ? dtcm_rdata_valid : bus_rdata_valid;
	assign rdata       = dtcm_sel_q ? dtcm_rdata : bus_rdata;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			state_q    <= MEM_IDLE;
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= 1'b0;
			case (state_q)
				MEM_IDLE: begin
					if (accept && ex_mem)
						state_q <= MEM_REQ;
					else if (accept)
						wb_valid_q <= 1'b1;	// alu op passes straight on
				end
				MEM_REQ: begin
					if (req_done) begin
						if (wr_q) begin
							state_q    <= MEM_IDLE;
							wb_valid_q <= 1'b1;
						end else begin
							state_q <= MEM_WAIT;
						end
					end
				end
				MEM_WAIT: begin
					if (rdata_valid) begin
						state_q    <= MEM_IDLE;
						wb_valid_q <= 1'b1;
					end
				end
				default: state_q <= MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (accept) begin
			op_q       <= ex.op;
			rd_q       <= ex.rd;
			result_q   <= ex.result;
			wdata_q    <= wdata;
			strobe_q   <= strobe;
			wr_q       <= is_store(ex.op);
			dtcm_sel_q <= hit_dtcm;
		end
		if (state_q == MEM_WAIT && rdata_valid)
			load_data_q <= rdata;
	end

	assign word_addr = {result_q[XLEN-1:2], 2'b00};

	assign dtcm_access = (state_q == MEM_REQ) && dtcm_sel_q;
	assign dtcm_wr     = wr_q;
	assign dtcm_strobe = strobe_q;
	assign dtcm_addr   = word_addr;
	assign dtcm_wdata  = wdata_q;

	assign bus_access = (state_q == MEM_REQ) && !dtcm_sel_q;
	assign bus_wr     = wr_q;
	assign bus_strobe = strobe_q;
	assign bus_addr   = word_addr;
	assign bus_wdata  = wdata_q;

	assign wb.valid     = wb_valid_q;
	assign wb.op        = op_q;
	assign wb.rd        = rd_q;
	assign wb.result    = result_q;
	assign wb.load_data = load_data_q;

endmodule

//--- src/wb_ctrl.sv
// registered register-write port; stores and writes to x0 never raise wb_valid
`timescale 1ns/1ps

module wb_ctrl import core_pkg::*; (
	input  logic              cpu_clk,
	input  logic              rst,
	wb_if.sink                wb,
	output logic              wb_valid,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0]   wb_data
);

	logic [7:0]      ld_byte;
	logic [15:0]     ld_half;
	logic [XLEN-1:0] wr_data;
	logic            wr_en;

	// lane select from the byte address carried in result
	always_comb begin
		case (wb.result[1:0])
			2'd0:    ld_byte = wb.load_data[7:0];
			2'd1:    ld_byte = wb.load_data[15:8];
			2'd2:    ld_byte = wb.load_data[23:16];
			default: ld_byte = wb.load_data[31:24];
		endcase
		ld_half = wb.result[1] ? wb.load_data[31:16] : wb.load_data[15:0];
	end

	always_comb begin
		case (wb.op)
			OP_LB:   wr_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
			OP_LBU:  wr_data = {{(XLEN-8){1'b0}}, ld_byte};
			OP_LH:   wr_data = {{(XLEN-16){ld_half[15]}}, ld_half};
			OP_LHU:  wr_data = {{(XLEN-16){1'b0}}, ld_half};
			OP_LW:   wr_data = wb.load_data;
			default: wr_data = wb.result;	// alu ops
		endcase
	end

	assign wr_en = wb.valid && !is_store(wb.op) && (wb.rd != '0);

	always_ff @(posedge cpu_clk) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= wr_en;
	end

	always_ff @(posedge cpu_clk) begin
		if (wr_en) begin
			wb_rd   <= wb.rd;
			wb_data <= wr_data;
		end
	end

endmodule

//--- src/exec_pipe.sv
// execute back end: pre-decoded ops only, no fetch/decode, no traps, one memory op in flight
`timescale 1ns/1ps

module exec_pipe import core_pkg::*; (
	input  logic              cpu_clk,
	input  logic              rst,

	// issue
	input  logic              issue_valid,
	output logic              issue_ready,
	input  exec_op_e          issue_op,
	input  logic [REG_AW-1:0] issue_rd,
	input  logic [XLEN-1:0]   issue_src1,
	input  logic [XLEN-1:0]   issue_src2,
	input  logic [XLEN-1:0]   issue_imm,

	// dtcm
	output logic              dtcm_access,
	input  logic              dtcm_ready,
	output logic              dtcm_wr,
	output logic [STRB_W-1:0] dtcm_strobe,
	output logic [XLEN-1:0]   dtcm_addr,
	output logic [XLEN-1:0]   dtcm_wdata,
	input  logic [XLEN-1:0]   dtcm_rdata,
	input  logic              dtcm_rdata_valid,

	// system bus
	output logic              bus_access,
	input  logic              bus_full,
	output logic              bus_wr,
	output logic [STRB_W-1:0] bus_strobe,
	output logic [XLEN-1:0]   bus_addr,
	output logic [XLEN-1:0]   bus_wdata,
	input  logic [XLEN-1:0]   bus_rdata,
	input  logic              bus_rdata_valid,

	// register write
	output logic              wb_valid,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0]   wb_data
);

	stage_if u_stage_if ();
	wb_if    u_wb_if ();

	alu_stage u_alu_stage (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_src1  (issue_src1),
		.issue_src2  (issue_src2),
		.issue_imm   (issue_imm),
		.ex          (u_stage_if.source)
	);

	dmem_ctrl u_dmem_ctrl (
		.cpu_clk          (cpu_clk),
		.rst              (rst),
		.dtcm_access      (dtcm_access),
		.dtcm_ready       (dtcm_ready),
		.dtcm_wr          (dtcm_wr),
		.dtcm_strobe      (dtcm_strobe),
		.dtcm_addr        (dtcm_addr),
		.dtcm_wdata       (dtcm_wdata),
		.dtcm_rdata       (dtcm_rdata),
		.dtcm_rdata_valid (dtcm_rdata_valid),
		.bus_access       (bus_access),
		.bus_full         (bus_full),
		.bus_wr           (bus_wr),
		.bus_strobe       (bus_strobe),
		.bus_addr         (bus_addr),
		.bus_wdata        (bus_wdata),
		.bus_rdata        (bus_rdata),
		.bus_rdata_valid  (bus_rdata_valid),
		.ex               (u_stage_if.sink),
		.wb               (u_wb_if.source)
	);

	wb_ctrl u_wb_ctrl (
		.cpu_clk  (cpu_clk),
		.rst      (rst),
		.wb       (u_wb_if.sink),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

endmodule

//--- verif/tb_mem_model.sv
// one port, sparse words; random stalls, read data 1 to 4 cycles later, one read at a time
`timescale 1ns/1ps

module tb_mem_model import core_pkg::*; (
	input  logic              cpu_clk,
	input  logic              rst,
	input  logic              access,
	output logic              ready,
	input  logic              wr,
	input  logic [STRB_W-1:0] strobe,
	input  logic [XLEN-1:0]   addr,
	input  logic [XLEN-1:0]   wdata,
	output logic [XLEN-1:0]   rdata,
	output logic              rdata_valid
);

	int              seed = 32'h2be8_4226;
	int              lat;	// latency offered to the next read
	int              delay;	// cycles left until read data, 0 when idle
	logic [XLEN-1:0] raddr;
	logic [XLEN-1:0] wtmp;
	logic [XLEN-1:0] mem [logic [XLEN-1:0]];

	// unwritten words give a pattern built from every address bit
	function automatic logic [XLEN-1:0] read_word(logic [XLEN-1:0] a);
		return mem.exists(a) ? mem[a] : (a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9);
	endfunction

	always @(posedge cpu_clk) begin
		if (rst) begin
			delay = 0;
		end else if (access && ready) begin
			if (wr) begin
				wtmp = read_word(addr);
				for (int i = 0; i < STRB_W; i++)
					if (strobe[i])
						wtmp[8*i +: 8] = wdata[8*i +: 8];	// only strobed lanes change
				mem[addr] = wtmp;
			end else begin
				raddr = addr;
				delay = lat;
			end
		end else if (delay > 0) begin
			delay = delay - 1;
		end
	end

	initial begin
		ready       = 1'b0;
		rdata       = '0;
		rdata_valid = 1'b0;
		lat         = 1;
		forever begin
			@(negedge cpu_clk);
			ready       = ($random(seed) & 3) != 0;	// stalls about one cycle in four
			lat         = 1 + ($random(seed) & 3);
			rdata_valid = (delay == 1);
			if (delay == 1)
				rdata = read_word(raddr);
		end
	end

endmodule

//--- verif/tb_exec_pipe.sv
// random pre-decoded ops through exec_pipe; loads only target words written by the initial stores
`timescale 1ns/1ps

module tb_exec_pipe import core_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 8;
	localparam int N_RANDOM   = 400;
	localparam int N_TOTAL    = N_RANDOM + 8;	// plus the initial word stores

	logic              cpu_clk;
	logic              rst;
	logic              issue_valid;
	logic              issue_ready;
	exec_op_e          issue_op;
	logic [REG_AW-1:0] issue_rd;
	logic [XLEN-1:0]   issue_src1;
	logic [XLEN-1:0]   issue_src2;
	logic [XLEN-1:0]   issue_imm;
	logic              dtcm_access;
	logic              dtcm_ready;
	logic              dtcm_wr;
	logic [STRB_W-1:0] dtcm_strobe;
	logic [XLEN-1:0]   dtcm_addr;
	logic [XLEN-1:0]   dtcm_wdata;
	logic [XLEN-1:0]   dtcm_rdata;
	logic              dtcm_rdata_valid;
	logic              bus_access;
	logic              bus_full;
	logic              bus_ok;
	logic              bus_wr;
	logic [STRB_W-1:0] bus_strobe;
	logic [XLEN-1:0]   bus_addr;
	logic [XLEN-1:0]   bus_wdata;
	logic [XLEN-1:0]   bus_rdata;
	logic              bus_rdata_valid;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;

	int                     seed = 32'h2be8_4226;
	logic [XLEN-1:0]        mirror [logic [XLEN-1:0]];	// word image of both memories
	logic [XLEN-1:0]        addr_tab [8];
	logic [REG_AW+XLEN-1:0] exp_q [$];	// {rd, data}
	logic [REG_AW+XLEN-1:0] wb_exp;
	logic [XLEN+5:0]        req_q [$];	// {bus, wr, strobe, word address}
	logic [XLEN+5:0]        req_seen;

	exec_pipe uut (.*);

	tb_mem_model u_dtcm_mem (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.access      (dtcm_access),
		.ready       (dtcm_ready),
		.wr          (dtcm_wr),
		.strobe      (dtcm_strobe),
		.addr        (dtcm_addr),
		.wdata       (dtcm_wdata),
		.rdata       (dtcm_rdata),
		.rdata_valid (dtcm_rdata_valid)
	);

	tb_mem_model u_bus_mem (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.access      (bus_access),
		.ready       (bus_ok),
		.wr          (bus_wr),
		.strobe      (bus_strobe),
		.addr        (bus_addr),
		.wdata       (bus_wdata),
		.rdata       (bus_rdata),
		.rdata_valid (bus_rdata_valid)
	);

	assign bus_full = !bus_ok;
	assign req_seen = bus_access ? {1'b1, bus_wr, bus_strobe, bus_addr}
	                             : {1'b0, dtcm_wr, dtcm_strobe, dtcm_addr};

	initial begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	task automatic abort(string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp)
			abort($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	// register write value of one op, loads read the mirror
	function automatic logic [XLEN-1:0] exec_ref(exec_op_e op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
		logic [XLEN-1:0] ea;
		logic [XLEN-1:0] word;
		logic [7:0]      b8;
		logic [15:0]     h16;
		logic [4:0]      sh;
		ea   = a + imm;
		sh   = b[4:0];
		word = mirror.exists({ea[31:2], 2'b00}) ? mirror[{ea[31:2], 2'b00}] : '0;
		b8   = 8'(word >> (8 * ea[1:0]));
		h16  = 16'(word >> (16 * ea[1]));	// bit 0 ignored for halves
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << sh;
			OP_SRL:  return a >> sh;
			OP_SRA:  return (a >> sh) | (a[31] ? ~({XLEN{1'b1}} >> sh) : '0);
			OP_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			OP_SLTU: return {31'b0, a < b};
			OP_LB:   return {{24{b8[7]}}, b8};
			OP_LBU:  return {24'b0, b8};
			OP_LH:   return {{16{h16[15]}}, h16};
			OP_LHU:  return {16'b0, h16};
			default: return word;	// lw
		endcase
	endfunction

	// port, direction, lanes and word address the access must show
	function automatic logic [XLEN+5:0] req_ref(exec_op_e op, logic [XLEN-1:0] ea);
		logic              in_dtcm;
		logic [STRB_W-1:0] st;
		in_dtcm = (ea >= DTCM_BASE) && (ea <= DTCM_BASE + DTCM_SIZE - 32'h1);
		case (op)
			OP_LB, OP_LBU, OP_SB: st = 4'b0001 << ea[1:0];
			OP_LH, OP_LHU, OP_SH: st = ea[1] ? 4'b1100 : 4'b0011;
			default:              st = 4'b1111;
		endcase
		return {!in_dtcm, op inside {OP_SB, OP_SH, OP_SW}, st, ea[31:2], 2'b00};
	endfunction

	function automatic void store_mirror(exec_op_e op, logic [XLEN-1:0] ea, logic [XLEN-1:0] d);
		logic [XLEN-1:0] key;
		logic [XLEN-1:0] w;
		key = {ea[31:2], 2'b00};
		w   = mirror.exists(key) ? mirror[key] : '0;
		case (op)
			OP_SB:   w[8*ea[1:0] +: 8] = d[7:0];
			OP_SH:   w[16*ea[1] +: 16] = d[15:0];
			default: w = d;
		endcase
		mirror[key] = w;
	endfunction

	// drive on the falling edge, the transfer happens at the next rising edge
	task automatic issue_one(exec_op_e op, logic [REG_AW-1:0] rd, logic [XLEN-1:0] s1,
			logic [XLEN-1:0] s2, logic [XLEN-1:0] imm);
		logic mem_op;
		logic st_op;
		mem_op = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
		st_op  = op inside {OP_SB, OP_SH, OP_SW};
		@(negedge cpu_clk);
		issue_valid = 1'b1;
		issue_op    = op;
		issue_rd    = rd;
		issue_src1  = s1;
		issue_src2  = s2;
		issue_imm   = imm;
		while (!issue_ready)
			@(negedge cpu_clk);
		if (!st_op && rd != '0)
			exp_q.push_back({rd, exec_ref(op, s1, s2, imm)});
		if (mem_op)
			req_q.push_back(req_ref(op, s1 + imm));
		if (st_op)
			store_mirror(op, s1 + imm, s2);
	endtask

	always @(posedge cpu_clk) begin
		if (!rst && wb_valid) begin
			if (exp_q.size() == 0) begin
				abort("register write seen with no operation expecting one");
			end else begin
				wb_exp = exp_q.pop_front();
				check_value("wb_rd", 64'(wb_rd), 64'(wb_exp[XLEN +: REG_AW]));
				check_value("wb_data", 64'(wb_data), 64'(wb_exp[XLEN-1:0]));
			end
		end
		if (!rst && ((dtcm_access && dtcm_ready) || (bus_access && !bus_full))) begin
			if (req_q.size() == 0)
				abort("memory port accessed with no load or store pending");
			else
				check_value("mem_req", 64'(req_seen), 64'(req_q.pop_front()));
		end
	end

	initial begin
		exec_op_e        op;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0] s1;
		logic [XLEN-1:0] target;
		int              k;
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue_op    = OP_ADD;
		issue_rd    = '0;
		issue_src1  = '0;
		issue_src2  = '0;
		issue_imm   = '0;
		// window edges on both sides, half inside the dtcm and half on the bus
		addr_tab = '{DTCM_BASE, DTCM_BASE + 32'h1230, DTCM_BASE + DTCM_SIZE - 32'h4,
			DTCM_BASE + 32'h40, DTCM_BASE - 32'h4, DTCM_BASE + DTCM_SIZE,
			32'h8000_0100, 32'h0000_0040};
		repeat (RST_CYCLES) @(posedge cpu_clk);
		@(negedge cpu_clk);
		rst = 1'b0;
		check_value("issue_ready/wb_valid/dtcm_access/bus_access",
			64'({issue_ready, wb_valid, dtcm_access, bus_access}), 64'(0));
		repeat (5) @(negedge cpu_clk);	// idle, nothing may move yet

		for (int i = 0; i < 8; i++)
			issue_one(OP_SW, 5'(i), 32'h0, $random(seed), addr_tab[i]);

		for (int i = 0; i < N_RANDOM; i++) begin
			k  = $unsigned($random(seed)) % 18;
			op = exec_op_e'(k);
			rd = (($random(seed) & 7) == 0) ? 5'd0 : 5'($random(seed));
			s1 = $random(seed);
			if (k < 10) begin
				issue_one(op, rd, s1, $random(seed), $random(seed));
			end else begin
				target = addr_tab[$unsigned($random(seed)) % 8] + ($random(seed) & 3);
				issue_one(op, rd, s1, $random(seed), target - s1);
			end
		end
		@(negedge cpu_clk);
		issue_valid = 1'b0;

		while (exp_q.size() != 0 || req_q.size() != 0)
			@(negedge cpu_clk);
		repeat (20) @(negedge cpu_clk);	// room for a stray duplicate
		$display("TEST OK");
		$finish;
	end

	initial begin
		#((RST_CYCLES + 40 * N_TOTAL) * CLK_PERIOD);
		abort("timeout, writeback stalled before all operations completed");
	end

endmodule

//--- exec_pipe.f
common/core_pkg.sv
common/stage_if.sv
common/wb_if.sv
src/alu_stage.sv
dmem/dmem_ctrl.sv
src/wb_ctrl.sv
src/exec_pipe.sv
verif/tb_mem_model.sv
verif/tb_exec_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f exec_pipe.f --top-module tb_exec_pipe -o sim_exec_pipe

# the log decides the result, a fatal exit still leaves its log behind
./obj_dir/sim_exec_pipe > sim.log 2>&1 || true
cat sim.log

grep -qx "TEST OK" sim.log
echo "simulation passed"
